// File: common/sound_pkg.sv
// Sound board shared types

package sound_pkg;

    // audio widths
    localparam int SAMPLE_W = 16;
    localparam int PCM_W    = 14;
    localparam int GAIN_W   = 8;
    localparam int ADDR_W   = 18;

    // mixer-side signed sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // player output, byte placed in the top bits
    typedef logic signed [PCM_W-1:0] pcm_t;

    // 4.4 fixed point, 8'h10 is unity
    typedef logic [GAIN_W-1:0] gain_t;

    // user level knob
    typedef logic [1:0] level_t;

    // sample ROM byte address
    typedef logic [ADDR_W-1:0] rom_addr_t;

    // one CPU write cycle towards the player
    typedef struct packed {
        logic [1:0] reg_sel; // 0..2 start address, 3 control
        logic [7:0] data;
    } cpu_wr_t;

    // fetch sequencer
    // REQUEST: ready to open a fetch on the next enabled cycle
    // WAIT: rom_cs high until rom_ok
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT
    } pcm_state_e;

    // sample byte that terminates playback
    localparam logic [7:0] pcm_end_byte = 8'h80;

endpackage

// File: rtl/sound_gain.sv
// Level to gain conversion
`timescale 1ns/1ns

module sound_gain (
    input  logic                CLK96,
    input  logic                RESET96,
    input  sound_pkg::level_t   fx_level,
    input  sound_pkg::level_t   fm_level,
    input  logic                pcm_en,
    input  logic                fm_en,
    output sound_pkg::gain_t    fm_gain,
    output sound_pkg::gain_t    pcm_gain
);

    // level knob to 4.4 gain
    function automatic sound_pkg::gain_t level_gain(input sound_pkg::level_t level);
        sound_pkg::gain_t g;
        case (level)
            2'd0:    g = 8'h20; // 200%
            2'd1:    g = 8'h0c; // 75%
            2'd2:    g = 8'h10; // unity
            default: g = 8'h18; // 150%
        endcase
        return g;
    endfunction

    // one register stage, a disabled source gets zero gain
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            fm_gain  <= '0;
            pcm_gain <= '0;
        end else begin
            fm_gain  <= fm_en  ? level_gain(fm_level) : '0;
            pcm_gain <= pcm_en ? level_gain(fx_level) : '0;
        end
    end

endmodule

// File: mixer/sound_mixer.sv
// Four channel saturating mixer
`timescale 1ns/1ns

module sound_mixer #(
    parameter int W0   = 16,
    parameter int W1   = 16,
    parameter int W2   = 16,
    parameter int W3   = 16,
    parameter int WOUT = 16
) (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  logic signed [W0-1:0]   ch0,
    input  logic signed [W1-1:0]   ch1,
    input  logic signed [W2-1:0]   ch2,
    input  logic signed [W3-1:0]   ch3,
    input  sound_pkg::gain_t       gain0,
    input  sound_pkg::gain_t       gain1,
    input  sound_pkg::gain_t       gain2,
    input  sound_pkg::gain_t       gain3,
    output logic signed [WOUT-1:0] mixed,
    output logic                   peak
);

    // widest channel sets the arithmetic width
    localparam int WA = (W0 > W1) ? W0 : W1;
    localparam int WB = (W2 > W3) ? W2 : W3;
    localparam int WM = (WA > WB) ? WA : WB;
    localparam int WP = WM + $bits(sound_pkg::gain_t) + 1; // gain used as positive signed
    localparam int WS = WP + 2;                             // room for four terms

    logic signed [WP-1:0] prod0;
    logic signed [WP-1:0] prod1;
    logic signed [WP-1:0] prod2;
    logic signed [WP-1:0] prod3;

    logic signed [WS-1:0]   sum;
    logic signed [WS-1:0]   shifted;
    logic                   ovf;
    logic signed [WOUT-1:0] sat;

    // stage one
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            prod0 <= '0;
            prod1 <= '0;
            prod2 <= '0;
            prod3 <= '0;
        end else begin
            prod0 <= ch0 * $signed({1'b0, gain0});
            prod1 <= ch1 * $signed({1'b0, gain1});
            prod2 <= ch2 * $signed({1'b0, gain2});
            prod3 <= ch3 * $signed({1'b0, gain3});
        end
    end

    // sum, drop the 4 fraction bits, clamp
    always_comb begin
        sum     = prod0 + prod1 + prod2 + prod3;
        shifted = sum >>> 4;
        // out of range when the bits above WOUT are not all sign copies
        ovf = shifted[WS-1:WOUT-1] != {(WS-WOUT+1){shifted[WS-1]}};
        if (!ovf)
            sat = shifted[WOUT-1:0];
        else if (shifted[WS-1])
            sat = {1'b1, {(WOUT-1){1'b0}}}; // most negative
        else
            sat = {1'b0, {(WOUT-1){1'b1}}}; // most positive
    end

    // stage two
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            mixed <= '0;
            peak  <= 1'b0;
        end else begin
            mixed <= sat;
            peak  <= ovf;
        end
    end

endmodule

// File: pcm/pcm_player.sv
// PCM sample player
`timescale 1ns/1ns

module pcm_player (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  logic                 cen,
    input  logic                 cpu_we,
    input  sound_pkg::cpu_wr_t   cpu_wr,
    output logic [7:0]           cpu_dout,
    output logic                 rom_cs,
    output sound_pkg::rom_addr_t rom_addr,
    input  logic [7:0]           rom_data,
    input  logic                 rom_ok,
    output sound_pkg::pcm_t      pcm,
    output logic                 pcm_sample,
    output logic                 busy
);

    sound_pkg::pcm_state_e state;
    sound_pkg::rom_addr_t  start_addr;
    sound_pkg::rom_addr_t  addr;
    logic                  reload;   // next fetch starts from start_addr
    logic                  ctrl_wr;
    logic                  at_end;

    assign ctrl_wr = cpu_we && (cpu_wr.reg_sel == 2'd3);
    assign at_end  = rom_data == sound_pkg::pcm_end_byte;

    // status read, busy only
    assign cpu_dout = {7'd0, busy};

    assign rom_cs   = state == sound_pkg::WAIT;
    assign rom_addr = addr;

    // start address bytes
    always_ff @(posedge CLK96) begin
        if (cpu_we) begin
            case (cpu_wr.reg_sel)
                2'd0: start_addr[7:0]   <= cpu_wr.data;
                2'd1: start_addr[15:8]  <= cpu_wr.data;
                2'd2: start_addr[17:16] <= cpu_wr.data[1:0];
                default: ; // control handled below
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state      <= sound_pkg::IDLE;
            addr       <= '0;
            reload     <= 1'b0;
            busy       <= 1'b0;
            pcm        <= '0;
            pcm_sample <= 1'b0;
        end else begin
            pcm_sample <= 1'b0;
            case (state)
                sound_pkg::IDLE: begin
                    if (busy)
                        state <= sound_pkg::REQUEST;
                end
                sound_pkg::REQUEST: begin
                    if (!busy) begin
                        state <= sound_pkg::IDLE;
                    end else if (cen) begin // paused player opens no fetch
                        state <= sound_pkg::WAIT;
                        if (reload) begin
                            addr   <= start_addr;
                            reload <= 1'b0;
                        end
                    end
                end
                sound_pkg::WAIT: begin
                    // address and cs stay put until the ROM answers
                    if (rom_ok) begin
                        if (!busy || reload) begin
                            // stopped or restarted meanwhile, drop the byte
                            state <= busy ? sound_pkg::REQUEST : sound_pkg::IDLE;
                        end else if (at_end) begin
                            busy  <= 1'b0;
                            pcm   <= '0;
                            state <= sound_pkg::IDLE;
                        end else begin
                            pcm        <= {rom_data, 6'd0}; // byte into top bits
                            pcm_sample <= 1'b1;
                            addr       <= addr + 1'b1;
                            state      <= sound_pkg::REQUEST;
                        end
                    end
                end
                default: state <= sound_pkg::IDLE;
            endcase

            // control write wins over the sequencer
            if (ctrl_wr) begin
                if (cpu_wr.data[0]) begin
                    busy   <= 1'b1;
                    reload <= 1'b1;
                end else begin
                    busy   <= 1'b0;
                    reload <= 1'b0;
                    pcm    <= '0;
                end
            end
        end
    end

endmodule

// File: rtl/sound_board.sv
// Arcade sound board top
`timescale 1ns/1ns

module sound_board (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  logic                 pcm_cen,
    input  logic                 pause,
    input  sound_pkg::sample_t   fm_left,
    input  sound_pkg::sample_t   fm_right,
    input  logic                 fm_sample,
    input  logic                 cpu_we,
    input  sound_pkg::cpu_wr_t   cpu_wr,
    output logic [7:0]           cpu_dout,
    output logic                 rom_cs,
    output sound_pkg::rom_addr_t rom_addr,
    input  logic [7:0]           rom_data,
    input  logic                 rom_ok,
    input  sound_pkg::level_t    fx_level,
    input  sound_pkg::level_t    fm_level,
    input  logic                 pcm_en,
    input  logic                 fm_en,
    input  logic                 audio_mix,
    output sound_pkg::sample_t   left,
    output sound_pkg::sample_t   right,
    output logic                 sample,
    output logic                 peak,
    output logic                 busy
);

    localparam int SW = sound_pkg::SAMPLE_W;
    localparam int PW = sound_pkg::PCM_W;

    sound_pkg::sample_t fm_left_r;
    sound_pkg::sample_t fm_right_r;
    sound_pkg::pcm_t    pcm;
    sound_pkg::pcm_t    pcm_r;
    logic               pcm_sample;
    logic               player_cen;

    sound_pkg::gain_t   fm_gain;
    sound_pkg::gain_t   pcm_gain;

    sound_pkg::sample_t left_stereo;
    sound_pkg::sample_t right_stereo;
    sound_pkg::sample_t mono;
    logic               peak_left;
    logic               peak_right;
    logic               peak_mono;

    assign player_cen = pcm_cen & ~pause;
    assign sample     = fm_sample; // FM rate marks the output rate

    // input stage ahead of the mixers
    always_ff @(posedge CLK96) begin
        fm_left_r  <= fm_left;
        fm_right_r <= fm_right;
        pcm_r      <= pcm;
    end

    sound_gain u_gain (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .fx_level (fx_level),
        .fm_level (fm_level),
        .pcm_en   (pcm_en),
        .fm_en    (fm_en),
        .fm_gain  (fm_gain),
        .pcm_gain (pcm_gain)
    );

    sound_mixer #(.W0(SW), .W1(PW), .W2(SW), .W3(SW), .WOUT(SW)) u_mix_left (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .ch0     (fm_left_r),
        .ch1     (pcm_r),
        .ch2     ('0),
        .ch3     ('0),
        .gain0   (fm_gain),
        .gain1   (pcm_gain),
        .gain2   ('0),
        .gain3   ('0),
        .mixed   (left_stereo),
        .peak    (peak_left)
    );

    sound_mixer #(.W0(SW), .W1(PW), .W2(SW), .W3(SW), .WOUT(SW)) u_mix_right (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .ch0     (fm_right_r),
        .ch1     (pcm_r),
        .ch2     ('0),
        .ch3     ('0),
        .gain0   (fm_gain),
        .gain1   (pcm_gain),
        .gain2   ('0),
        .gain3   ('0),
        .mixed   (right_stereo),
        .peak    (peak_right)
    );

    // both FM sides plus PCM
    sound_mixer #(.W0(SW), .W1(PW), .W2(SW), .W3(SW), .WOUT(SW)) u_mix_mono (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .ch0     (fm_left_r),
        .ch1     (pcm_r),
        .ch2     (fm_right_r),
        .ch3     ('0),
        .gain0   (fm_gain),
        .gain1   (pcm_gain),
        .gain2   (fm_gain),
        .gain3   ('0),
        .mixed   (mono),
        .peak    (peak_mono)
    );

    assign left  = audio_mix ? left_stereo  : mono;
    assign right = audio_mix ? right_stereo : mono;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96)
            peak <= 1'b0;
        else
            peak <= audio_mix ? (peak_left | peak_right) : peak_mono;
    end

    pcm_player u_pcm (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .cen        (player_cen),
        .cpu_we     (cpu_we),
        .cpu_wr     (cpu_wr),
        .cpu_dout   (cpu_dout),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .pcm        (pcm),
        .pcm_sample (pcm_sample),
        .busy       (busy)
    );

endmodule

// File: testbench/sound_board_checker.sv
// Sound board protocol assertions
`timescale 1ns/1ns

module sound_board_checker (
    input logic                 CLK96,
    input logic                 RESET96,
    input logic                 rom_cs,
    input logic                 rom_ok,
    input sound_pkg::rom_addr_t rom_addr,
    input logic                 pcm_sample,
    input logic                 peak
);

    // open fetch keeps its address until the ROM answers
    rom_addr_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        rom_cs && !rom_ok |=> $stable(rom_addr))
        else $error("rom_addr changed while a ROM request was open");

    pcm_sample_pulse: assert property (@(posedge CLK96) disable iff (RESET96)
        pcm_sample |=> !pcm_sample)
        else $error("pcm_sample high for two cycles in a row");

    // first edge out of reset
    peak_after_reset: assert property (@(posedge CLK96) $fell(RESET96) |-> !peak)
        else $error("peak high right after reset");

endmodule

bind sound_board sound_board_checker u_checker (
    .CLK96      (CLK96),
    .RESET96    (RESET96),
    .rom_cs     (rom_cs),
    .rom_ok     (rom_ok),
    .rom_addr   (rom_addr),
    .pcm_sample (pcm_sample),
    .peak       (peak)
);

// File: testbench/sound_board_tb.sv
// Sound board testbench
`timescale 1ns/1ns

module sound_board_tb;

    logic                 CLK96;
    logic                 RESET96;
    logic                 pcm_cen;
    logic                 pause;
    sound_pkg::sample_t   fm_left;
    sound_pkg::sample_t   fm_right;
    logic                 fm_sample;
    logic                 cpu_we;
    sound_pkg::cpu_wr_t   cpu_wr;
    logic [7:0]           cpu_dout;
    logic                 rom_cs;
    sound_pkg::rom_addr_t rom_addr;
    logic [7:0]           rom_data;
    logic                 rom_ok;
    sound_pkg::level_t    fx_level;
    sound_pkg::level_t    fm_level;
    logic                 pcm_en;
    logic                 fm_en;
    logic                 audio_mix;
    sound_pkg::sample_t   left;
    sound_pkg::sample_t   right;
    logic                 sample;
    logic                 peak;
    logic                 busy;

    logic [7:0]           rom_mem [0:262143]; // 256 kB sample ROM
    logic [7:0]           clip[$];            // bytes of the clip under test
    sound_pkg::rom_addr_t addr_log[$];        // addresses the ROM answered
    integer               seed = 32'hb4a2;
    int                   rom_wait;
    int                   errors;
    int                   checks;
    int                   tests;
    int                   err_start;

    sound_board i_sound_board (.*);

    initial begin
        CLK96 = 1'b0;
        forever #50 CLK96 = ~CLK96;
    end

    // ROM model answering 0 to 5 cycles after rom_cs
    initial begin
        rom_ok   = 1'b0;
        rom_data = '0;
        rom_wait = -1;
        forever begin
            @(negedge CLK96);
            if (rom_ok) begin
                rom_ok   = 1'b0; // byte taken on the last rising edge
                rom_wait = -1;
            end else if (rom_cs) begin
                if (rom_wait < 0)
                    rom_wait = {$random(seed)} % 6;
                if (rom_wait == 0) begin
                    rom_data = rom_mem[rom_addr];
                    rom_ok   = 1'b1;
                    addr_log.push_back(rom_addr);
                end else begin
                    rom_wait--;
                end
            end
        end
    end

    function automatic int level_to_gain(input int level);
        case (level)
            0:       return 32;
            1:       return 12;
            2:       return 16;
            default: return 24;
        endcase
    endfunction

    // weighted sum shifted down by 4 and clamped to 16 bits
    function automatic int mix_expect(input int a, input int ga, input int b, input int gb);
        int s;
        s = (a * ga + b * gb) >>> 4;
        if (s > 32767)
            return 32767;
        if (s < -32768)
            return -32768;
        return s;
    endfunction

    task check_value(input string name, input integer expected, input integer actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task step(input int n);
        repeat (n) @(negedge CLK96);
    endtask

    task cpu_write(input logic [1:0] sel, input logic [7:0] value);
        cpu_wr.reg_sel = sel;
        cpu_wr.data    = value;
        cpu_we         = 1'b1;
        @(negedge CLK96);
        cpu_we = 1'b0;
    endtask

    task start_from(input sound_pkg::rom_addr_t a);
        cpu_write(2'd0, a[7:0]);
        cpu_write(2'd1, a[15:8]);
        cpu_write(2'd2, {6'd0, a[17:16]});
        cpu_write(2'd3, 8'h01);
    endtask

    task load_rom;
        logic [17:0] a;
        for (int i = 0; i < 262144; i++) begin
            a = i[17:0];
            rom_mem[i] = a[7:0] ^ a[15:8] ^ {6'd0, a[17:16]};
        end
    endtask

    task place_clip(input sound_pkg::rom_addr_t start);
        for (int i = 0; i < clip.size(); i++)
            rom_mem[start + i] = clip[i];
    endtask

    // counts pcm_sample pulses and can stop at the first one
    task watch_pcm(input int limit, input bit first_only, output int n);
        int c;
        c = 0;
        n = 0;
        while (c < limit && !(first_only && n > 0)) begin
            @(negedge CLK96);
            n += i_sound_board.pcm_sample;
            c++;
        end
    endtask

    // an open fetch may still finish
    task wait_rom_idle(input int limit);
        int c;
        c = 0;
        while (rom_cs && c < limit) begin
            @(negedge CLK96);
            c++;
        end
        if (rom_cs) begin
            errors++;
            $display("ROM request still open after %0d cycles", limit);
        end
    endtask

    task configure(input int fm_lvl, input bit fm_on, input int fx_lvl, input bit pcm_on,
                   input bit mix);
        fm_level  = fm_lvl;
        fm_en     = fm_on;
        fx_level  = fx_lvl;
        pcm_en    = pcm_on;
        audio_mix = mix;
        step(5); // gains and mixers settle
    endtask

    task begin_test;
        err_start = errors;
        tests++;
    endtask

    task end_test(input string name);
        $display("%s: %s", name, (errors == err_start) ? "passed" : "failed");
    endtask

    task fm_stereo_path;
        begin_test();
        configure(2, 1, 2, 0, 1);
        fm_left   = 16'sd1234;
        fm_right  = -16'sd567;
        fm_sample = 1'b1;
        step(2);
        check_value("left", 0, left);
        check_value("right", 0, right);
        step(1);
        check_value("left", mix_expect(1234, 16, 0, 0), left);
        check_value("right", mix_expect(-567, 16, 0, 0), right);
        check_value("sample", 1, sample);
        fm_sample = 1'b0;
        step(1);
        check_value("sample", 0, sample);
        end_test("fm stereo path");
    endtask

    task gain_levels;
        int x;
        begin_test();
        for (int lvl = 0; lvl < 4; lvl++) begin
            configure(lvl, 1, 2, 0, 1);
            x = (lvl % 2) ? -1001 - lvl : 1500 + lvl; // odd levels check rounding down
            fm_left = x;
            step(3);
            check_value("left", mix_expect(x, level_to_gain(lvl), 0, 0), left);
        end
        fm_en = 1'b0;
        step(5);
        check_value("left", 0, left);
        end_test("gain levels");
    endtask

    task mono_mix;
        begin_test();
        configure(3, 1, 2, 0, 0);
        fm_left  = 16'sd3000;
        fm_right = -16'sd1000;
        step(3);
        check_value("left", mix_expect(3000, 24, -1000, 24), left);
        check_value("right", mix_expect(3000, 24, -1000, 24), right);
        end_test("mono mix");
    endtask

    task saturation_peak;
        begin_test();
        configure(0, 1, 2, 0, 1);
        fm_left  = 16'sd20000;
        fm_right = 16'sd20000;
        step(3);
        check_value("left", 32767, left);
        check_value("right", 32767, right);
        check_value("peak", 0, peak);
        step(1);
        check_value("peak", 1, peak);
        fm_left  = -16'sd20000;
        fm_right = -16'sd20000;
        step(3);
        check_value("left", -32768, left);
        check_value("right", -32768, right);
        fm_left  = '0;
        fm_right = '0;
        step(5);
        check_value("peak", 0, peak);
        end_test("saturation and peak");
    endtask

    task pcm_playback;
        sound_pkg::rom_addr_t start;
        logic [3:0]           hist;
        int                   n;
        int                   cycles;
        begin_test();
        start = 18'h2_3456;
        clip  = '{8'h01, 8'h7f, 8'hc0, 8'h81, 8'h20, 8'hff, 8'h80};
        place_clip(start);
        configure(2, 0, 2, 1, 1);
        addr_log.delete();
        start_from(start);
        check_value("busy", 1, busy);
        hist   = '0;
        n      = 0;
        cycles = 0;
        // a pcm_sample shows on left three rising edges later
        while ((busy || hist != 4'd0) && cycles < 200) begin
            @(negedge CLK96);
            cycles++;
            hist = {hist[2:0], i_sound_board.pcm_sample};
            if (hist[3] && n < 6)
                check_value("left", $signed(clip[n]) * 64, left);
            n += hist[3];
        end
        if (cycles >= 200) begin
            errors++;
            $display("Playback did not end within 200 cycles");
        end
        check_value("pcm samples", 6, n);
        check_value("rom fetches", 7, addr_log.size());
        for (int i = 0; i < addr_log.size() && i < 7; i++)
            check_value("rom_addr", start + i, addr_log[i]);
        check_value("busy", 0, busy);
        check_value("cpu_dout", 0, cpu_dout);
        end_test("pcm playback");
    endtask

    task pause_stop;
        int n;
        begin_test();
        clip.delete();
        for (int i = 0; i < 40; i++)
            clip.push_back(8'(i * 5 + 1));
        clip.push_back(sound_pkg::pcm_end_byte);
        place_clip(18'h0_1000);
        start_from(18'h0_1000);
        watch_pcm(50, 1'b1, n);
        check_value("pcm samples before pause", 1, n);
        pause = 1'b1;
        wait_rom_idle(10);
        watch_pcm(40, 1'b0, n);
        check_value("pcm samples while paused", 0, n);
        pause = 1'b0;
        watch_pcm(50, 1'b1, n);
        if (n == 0) begin
            errors++;
            $display("Playback did not resume within 50 cycles after pause was released");
        end
        check_value("cpu_dout[0]", 1, cpu_dout[0]);
        cpu_write(2'd3, 8'h00);
        check_value("cpu_dout[0]", 0, cpu_dout[0]);
        watch_pcm(20, 1'b0, n);
        check_value("pcm samples after stop", 0, n);
        end_test("pause and stop");
    endtask

    initial begin
        RESET96   = 1'b1;
        pcm_cen   = 1'b1;
        pause     = 1'b0;
        fm_left   = '0;
        fm_right  = '0;
        fm_sample = 1'b0;
        cpu_we    = 1'b0;
        cpu_wr    = '0;
        fx_level  = 2'd2;
        fm_level  = 2'd2;
        pcm_en    = 1'b0;
        fm_en     = 1'b0;
        audio_mix = 1'b1;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        load_rom();
        step(8);
        RESET96 = 1'b0;
        fm_stereo_path();
        gain_levels();
        mono_mix();
        saturation_peak();
        pcm_playback();
        pause_stop();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: sound_board.f
common/sound_pkg.sv
rtl/sound_gain.sv
mixer/sound_mixer.sv
pcm/pcm_player.sv
rtl/sound_board.sv
testbench/sound_board_checker.sv
testbench/sound_board_tb.sv

// File: Makefile
SRCS := $(shell cat sound_board.f)

all: run

obj_dir/Vsound_board_tb: sound_board.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module sound_board_tb -f sound_board.f

run: obj_dir/Vsound_board_tb
	./obj_dir/Vsound_board_tb > sim.log 2>&1; cat sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
